// File: Makefile
# Verilator simulation of the RV32I pipeline testbench

VERILATOR ?= verilator
TOP ?= tb_rv_pipeline
FLIST ?= flist.f
BUILD ?= obj_dir
LOG ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "Variables: VERILATOR TOP FLIST BUILD LOG"

test:
	$(VERILATOR) --binary --timing --assert -f $(FLIST) --top-module $(TOP) \
		-Mdir $(BUILD) -o V$(TOP)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "all tests passed" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// File: flist.f
+incdir+test
rtl/rv_pkg.sv
rtl/reg_file.sv
rtl/fetch_decode.sv
rtl/alu_unit.sv
rtl/branch_unit.sv
rtl/execute_stage.sv
rtl/rv_pipeline.sv
test/tb_rv_pipeline.sv

// File: rtl/alu_unit.sv
`timescale 1ns/100ps
`default_nettype none

module alu_unit import rv_pkg::*; (
  input wire word_t pc,
  input wire word_t insn,
  input wire word_t rs1_val,
  input wire word_t rs2_val,
  input wire word_t imm_i,
  output word_t rd_data,
  output logic we
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic is_rr;
  logic alt;
  word_t operand_b;
  logic [4:0] shamt;
  word_t op_result;
  logic op_legal;

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];
  assign is_rr = opcode == opcode_reg_reg;
  assign alt = funct7 == funct7_alt;

  // Second operand is rs2 or the I immediate
  assign operand_b = is_rr ? rs2_val : imm_i;
  assign shamt = operand_b[4:0];

  // One datapath for both ALU forms
  always_comb begin
    case (funct3)
      funct3_add_sub: begin
        if (is_rr && alt) begin
          op_result = rs1_val - operand_b;
        end else begin
          op_result = rs1_val + operand_b;
        end
      end
      funct3_sll: op_result = rs1_val << shamt;
      funct3_slt: op_result = word_t'($signed(rs1_val) < $signed(operand_b));
      funct3_sltu: op_result = word_t'(rs1_val < operand_b);
      funct3_xor: op_result = rs1_val ^ operand_b;
      funct3_srl_sra: begin
        // Arithmetic shift keeps the sign
        if (alt) begin
          op_result = $signed(rs1_val) >>> shamt;
        end else begin
          op_result = rs1_val >> shamt;
        end
      end
      funct3_or: op_result = rs1_val | operand_b;
      default: op_result = rs1_val & operand_b;
    endcase
  end

  // funct7 must match the op
  always_comb begin
    if (is_rr) begin
      op_legal = funct7 == '0 ||
                 (alt && (funct3 == funct3_add_sub || funct3 == funct3_srl_sra));
    end else if (funct3 == funct3_sll) begin
      op_legal = funct7 == '0;
    end else if (funct3 == funct3_srl_sra) begin
      op_legal = funct7 == '0 || alt;
    end else begin
      op_legal = 1'b1;
    end
  end

  // Result select
  always_comb begin
    rd_data = '0;
    we = 1'b0;
    case (opcode)
      opcode_lui: begin
        rd_data = {insn[31:12], 12'b0};
        we = 1'b1;
      end
      opcode_reg_imm, opcode_reg_reg: begin
        rd_data = op_result;
        we = op_legal;
      end
      opcode_jal: begin
        // Link address
        rd_data = pc + pc_step;
        we = 1'b1;
      end
      default: begin
        // Branches, ECALL and unknown encodings write nothing
        we = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/branch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module branch_unit import rv_pkg::*; (
  input wire word_t pc,
  input wire word_t insn,
  input wire word_t rs1_val,
  input wire word_t rs2_val,
  input wire word_t imm_b,
  input wire word_t imm_j,
  output logic taken,
  output word_t target
);

  logic [6:0] opcode;
  logic [2:0] funct3;

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];

  always_comb begin
    taken = 1'b0;
    target = pc + imm_b;
    case (opcode)
      opcode_branch: begin
        case (funct3)
          funct3_beq: taken = rs1_val == rs2_val;
          funct3_bne: taken = rs1_val != rs2_val;
          funct3_blt: taken = $signed(rs1_val) < $signed(rs2_val);
          funct3_bge: taken = $signed(rs1_val) >= $signed(rs2_val);
          funct3_bltu: taken = rs1_val < rs2_val;
          funct3_bgeu: taken = rs1_val >= rs2_val;
          // Reserved encodings fall through
          default: taken = 1'b0;
        endcase
      end
      opcode_jal: begin
        taken = 1'b1;
        target = pc + imm_j;
      end
      default: taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage import rv_pkg::*; (
  input wire clk,
  input wire rst,
  input wire exec_rec_t exec_in,
  input wire reg_idx_t mem_rd,
  input wire word_t mem_data,
  input wire mem_we,
  output logic branch_taken,
  output word_t branch_target,
  output mem_rec_t mem_rec
);

  exec_rec_t ex_q;
  word_t op1;
  word_t op2;
  word_t alu_data;
  logic alu_we;
  logic is_halt;

  // Execute register
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ex_q <= '0;
      ex_q.status <= cycle_reset;
    end else begin
      ex_q <= exec_in;
    end
  end

  // Producer one slot ahead sits in memory
  assign op1 = (mem_we && ex_q.rs1 != '0 && mem_rd == ex_q.rs1) ? mem_data : ex_q.rs1_data;
  assign op2 = (mem_we && ex_q.rs2 != '0 && mem_rd == ex_q.rs2) ? mem_data : ex_q.rs2_data;

  alu_unit alu_unit_i (
    .pc(ex_q.pc),
    .insn(ex_q.insn),
    .rs1_val(op1),
    .rs2_val(op2),
    .imm_i(ex_q.imm_i),
    .rd_data(alu_data),
    .we(alu_we)
  );

  branch_unit branch_unit_i (
    .pc(ex_q.pc),
    .insn(ex_q.insn),
    .rs1_val(op1),
    .rs2_val(op2),
    .imm_b(ex_q.imm_b),
    .imm_j(ex_q.imm_j),
    .taken(branch_taken),
    .target(branch_target)
  );

  // ECALL only, all upper bits clear
  assign is_halt = ex_q.insn[6:0] == opcode_environ && ex_q.insn[31:7] == '0;

  // Record handed to the memory register
  always_comb begin
    mem_rec.pc = ex_q.pc;
    mem_rec.insn = ex_q.insn;
    mem_rec.status = ex_q.status;
    mem_rec.rd = ex_q.rd;
    mem_rec.rd_data = alu_data;
    // rd x0 is no write at all
    mem_rec.we = alu_we && ex_q.rd != '0;
    mem_rec.halt = is_halt;
  end

  // Bubbles from decode stay inert through both units
  bubble_quiet: assert property (@(posedge clk) disable iff (rst)
    ex_q.status != cycle_no_stall |-> !(mem_rec.we || mem_rec.halt || branch_taken))
    else $error("bubble in execute raised we, halt or a redirect");

endmodule

`default_nettype wire

// File: rtl/fetch_decode.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_decode import rv_pkg::*; (
  input wire clk,
  input wire rst,
  input wire branch_taken,
  input wire word_t branch_target,
  output word_t pc_to_imem,
  input wire word_t insn_from_imem,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  input wire word_t rs1_data,
  input wire word_t rs2_data,
  input wire reg_idx_t mem_rd,
  input wire word_t mem_data,
  input wire mem_we,
  output exec_rec_t exec_rec
);

  word_t pc_q;

  // Decode register
  word_t dec_pc;
  word_t dec_insn;
  cycle_status_e dec_status;

  reg_idx_t dec_rd;
  word_t imm_i;
  word_t imm_b;
  word_t imm_j;
  word_t fwd_rs1;
  word_t fwd_rs2;

  // PC steps by one word unless execute redirects
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc_q <= '0;
    end else if (branch_taken) begin
      pc_q <= branch_target;
    end else begin
      pc_q <= pc_q + pc_step;
    end
  end

  assign pc_to_imem = pc_q;

  // Fetched word lands in decode, squashed on redirect
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      dec_pc <= '0;
      dec_insn <= '0;
      dec_status <= cycle_reset;
    end else if (branch_taken) begin
      dec_pc <= '0;
      dec_insn <= '0;
      dec_status <= cycle_taken_branch;
    end else begin
      dec_pc <= pc_q;
      dec_insn <= insn_from_imem;
      dec_status <= cycle_no_stall;
    end
  end

  // Field split
  assign rs1 = dec_insn[19:15];
  assign rs2 = dec_insn[24:20];
  assign dec_rd = dec_insn[11:7];

  // Sign-extended immediates
  assign imm_i = {{20{dec_insn[31]}}, dec_insn[31:20]};
  assign imm_b = {{19{dec_insn[31]}}, dec_insn[31], dec_insn[7], dec_insn[30:25],
                  dec_insn[11:8], 1'b0};
  assign imm_j = {{11{dec_insn[31]}}, dec_insn[31], dec_insn[19:12], dec_insn[20],
                  dec_insn[30:21], 1'b0};

  // Producer two slots ahead is in memory now
  assign fwd_rs1 = (mem_we && rs1 != '0 && mem_rd == rs1) ? mem_data : rs1_data;
  assign fwd_rs2 = (mem_we && rs2 != '0 && mem_rd == rs2) ? mem_data : rs2_data;

  // Next execute record, bubble when execute redirects
  always_comb begin
    exec_rec = '0;
    if (branch_taken) begin
      exec_rec.status = cycle_taken_branch;
    end else begin
      exec_rec.pc = dec_pc;
      exec_rec.insn = dec_insn;
      exec_rec.status = dec_status;
      exec_rec.rs1 = rs1;
      exec_rec.rs2 = rs2;
      exec_rec.rs1_data = fwd_rs1;
      exec_rec.rs2_data = fwd_rs2;
      exec_rec.rd = dec_rd;
      exec_rec.imm_i = imm_i;
      exec_rec.imm_b = imm_b;
      exec_rec.imm_j = imm_j;
    end
  end

  // Redirect targets keep fetch word aligned
  pc_aligned: assert property (@(posedge clk) disable iff (rst) pc_q[1:0] == 2'b00)
    else $error("fetch PC %h not word aligned", pc_q);

endmodule

`default_nettype wire

// File: rtl/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file import rv_pkg::*; (
  input wire clk,
  input wire rst,
  input wire reg_idx_t rd,
  input wire word_t rd_data,
  input wire we,
  input wire reg_idx_t rs1,
  input wire reg_idx_t rs2,
  output word_t rs1_data,
  output word_t rs2_data
);

  word_t regs [32];

  // Write port, x0 never written
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  // Read with bypass of the same-cycle write
  function automatic word_t read_port(input reg_idx_t idx);
    if (idx == '0) begin
      return '0;
    end else if (we && rd == idx) begin
      return rd_data;
    end
    return regs[idx];
  endfunction

  // Both ports follow the array and the write port as well as the index
  always_comb begin
    rs1_data = read_port(rs1);
    rs2_data = read_port(rs2);
  end

  // x0 stays zero whatever writeback presents
  x0_zero: assert property (@(posedge clk) disable iff (rst) regs[0] == '0)
    else $error("x0 holds a nonzero value");

endmodule

`default_nettype wire

// File: rtl/rv_pipeline.sv
`timescale 1ns/100ps
`default_nettype none

module rv_pipeline import rv_pkg::*; (
  input wire clk,
  input wire rst,
  output word_t pc_to_imem,
  input wire word_t insn_from_imem,
  output logic halt,
  output word_t trace_writeback_pc,
  output word_t trace_writeback_insn,
  output cycle_status_e trace_writeback_cycle_status,
  output logic trace_writeback_we,
  output reg_idx_t trace_writeback_rd,
  output word_t trace_writeback_data
);

  exec_rec_t exec_rec;
  mem_rec_t mem_next;
  mem_rec_t mem_q;
  mem_rec_t wb_q;
  logic branch_taken;
  word_t branch_target;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t rs1_data;
  word_t rs2_data;

  fetch_decode fetch_decode_i (
    .clk(clk),
    .rst(rst),
    .branch_taken(branch_taken),
    .branch_target(branch_target),
    .pc_to_imem(pc_to_imem),
    .insn_from_imem(insn_from_imem),
    .rs1(rs1),
    .rs2(rs2),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .mem_rd(mem_q.rd),
    .mem_data(mem_q.rd_data),
    .mem_we(mem_q.we),
    .exec_rec(exec_rec)
  );

  execute_stage execute_stage_i (
    .clk(clk),
    .rst(rst),
    .exec_in(exec_rec),
    .mem_rd(mem_q.rd),
    .mem_data(mem_q.rd_data),
    .mem_we(mem_q.we),
    .branch_taken(branch_taken),
    .branch_target(branch_target),
    .mem_rec(mem_next)
  );

  // Memory stage just passes through, then writeback
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mem_q <= '0;
      mem_q.status <= cycle_reset;
      wb_q <= '0;
      wb_q.status <= cycle_reset;
    end else begin
      mem_q <= mem_next;
      wb_q <= mem_q;
    end
  end

  reg_file reg_file_i (
    .clk(clk),
    .rst(rst),
    .rd(wb_q.rd),
    .rd_data(wb_q.rd_data),
    .we(wb_q.we),
    .rs1(rs1),
    .rs2(rs2),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  // Trace of the retiring slot
  assign halt = wb_q.halt;
  assign trace_writeback_pc = wb_q.pc;
  assign trace_writeback_insn = wb_q.insn;
  assign trace_writeback_cycle_status = wb_q.status;
  assign trace_writeback_we = wb_q.we;
  assign trace_writeback_rd = wb_q.rd;
  assign trace_writeback_data = wb_q.rd_data;

  // Every stage register carries a defined status from reset on
  wb_status_valid: assert property (@(posedge clk) disable iff (rst)
    wb_q.status != cycle_invalid)
    else $error("writeback status is cycle_invalid");

endmodule

`default_nettype wire

// File: rtl/rv_pkg.sv
`default_nettype none

package rv_pkg;

  // Datapath widths
  localparam int xlen = 32;
  localparam int reg_addr_w = 5;

  typedef logic [xlen-1:0] word_t;
  typedef logic [reg_addr_w-1:0] reg_idx_t;

  // Sequential fetch increment
  localparam word_t pc_step = 32'd4;

  // Major opcodes
  localparam logic [6:0] opcode_lui = 7'b01_101_11;
  localparam logic [6:0] opcode_reg_imm = 7'b00_100_11;
  localparam logic [6:0] opcode_reg_reg = 7'b01_100_11;
  localparam logic [6:0] opcode_branch = 7'b11_000_11;
  localparam logic [6:0] opcode_jal = 7'b11_011_11;
  localparam logic [6:0] opcode_environ = 7'b11_100_11;

  // ALU funct3, shared by register-immediate and register-register forms
  localparam logic [2:0] funct3_add_sub = 3'b000;
  localparam logic [2:0] funct3_sll = 3'b001;
  localparam logic [2:0] funct3_slt = 3'b010;
  localparam logic [2:0] funct3_sltu = 3'b011;
  localparam logic [2:0] funct3_xor = 3'b100;
  localparam logic [2:0] funct3_srl_sra = 3'b101;
  localparam logic [2:0] funct3_or = 3'b110;
  localparam logic [2:0] funct3_and = 3'b111;

  // Branch funct3
  localparam logic [2:0] funct3_beq = 3'b000;
  localparam logic [2:0] funct3_bne = 3'b001;
  localparam logic [2:0] funct3_blt = 3'b100;
  localparam logic [2:0] funct3_bge = 3'b101;
  localparam logic [2:0] funct3_bltu = 3'b110;
  localparam logic [2:0] funct3_bgeu = 3'b111;

  // Selects SUB and SRA/SRAI
  localparam logic [6:0] funct7_alt = 7'b0100000;

  // addi x0, x0, 0
  localparam word_t insn_nop = 32'h0000_0013;

  // What occupies the writeback slot this cycle
  typedef enum logic [1:0] {
    cycle_invalid = 2'd0,
    cycle_reset = 2'd1,
    cycle_no_stall = 2'd2,
    cycle_taken_branch = 2'd3
  } cycle_status_e;

  // Execute stage contents
  typedef struct packed {
    word_t pc;
    word_t insn;
    cycle_status_e status;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t rs1_data;
    word_t rs2_data;
    reg_idx_t rd;
    word_t imm_i;
    word_t imm_b;
    word_t imm_j;
  } exec_rec_t;

  // Memory and writeback stage contents
  typedef struct packed {
    word_t pc;
    word_t insn;
    cycle_status_e status;
    reg_idx_t rd;
    word_t rd_data;
    logic we;
    logic halt;
  } mem_rec_t;

endpackage

`default_nettype wire

// File: test/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// Architectural model of the supported RV32I subset
// Runs from pc 0 until ECALL and lists every retired instruction in order
function automatic void run_reference(input word_t words[$], output retire_t trace[$],
                                      output int taken);
  word_t regs [32];
  word_t pc;
  word_t next_pc;
  word_t insn;
  word_t a;
  word_t b;
  word_t c;
  word_t value;
  logic [4:0] sh;
  logic [2:0] f3;
  logic [6:0] f7;
  logic write;
  logic cond;
  logic halted;
  retire_t r;
  int idx;
  int steps;
  trace = {};
  taken = 0;
  foreach (regs[i]) regs[i] = '0;
  pc = '0;
  halted = 1'b0;
  steps = 0;
  while (!halted && steps < 4096) begin
    idx = int'(pc >> 2);
    insn = (idx < words.size()) ? words[idx] : insn_nop;
    f3 = insn[14:12];
    f7 = insn[31:25];
    a = regs[insn[19:15]];
    c = regs[insn[24:20]];
    // Register form takes rs2, immediate form the sign-extended I field
    b = (insn[6:0] == opcode_reg_reg) ? c : {{20{insn[31]}}, insn[31:20]};
    sh = b[4:0];
    value = '0;
    write = 1'b0;
    cond = 1'b0;
    next_pc = pc + 32'd4;
    case (insn[6:0])
      opcode_lui: begin
        value = {insn[31:12], 12'h000};
        write = 1'b1;
      end
      opcode_reg_imm, opcode_reg_reg: begin
        case (f3)
          funct3_add_sub: value = (insn[5] && f7 == funct7_alt) ? a - b : a + b;
          funct3_sll: value = a << sh;
          // Signed compare by flipping the sign bits
          funct3_slt: value = {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
          funct3_sltu: value = {31'b0, a < b};
          funct3_xor: value = a ^ b;
          funct3_srl_sra: begin
            value = a >> sh;
            // Fill vacated upper bits with the sign for SRA
            if (f7 == funct7_alt && a[31]) value = value | ~(32'hffff_ffff >> sh);
          end
          funct3_or: value = a | b;
          default: value = a & b;
        endcase
        // Reserved funct7 values retire without a write
        if (insn[5]) begin
          write = f7 == 7'b0 ||
                  (f7 == funct7_alt && (f3 == funct3_add_sub || f3 == funct3_srl_sra));
        end else if (f3 == funct3_sll) begin
          write = f7 == 7'b0;
        end else if (f3 == funct3_srl_sra) begin
          write = f7 == 7'b0 || f7 == funct7_alt;
        end else begin
          write = 1'b1;
        end
      end
      opcode_branch: begin
        case (f3)
          funct3_beq: cond = a == c;
          funct3_bne: cond = a != c;
          funct3_blt: cond = (a ^ 32'h8000_0000) < (c ^ 32'h8000_0000);
          funct3_bge: cond = (a ^ 32'h8000_0000) >= (c ^ 32'h8000_0000);
          funct3_bltu: cond = a < c;
          funct3_bgeu: cond = a >= c;
          default: cond = 1'b0;
        endcase
        if (cond) begin
          next_pc = pc + {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
          taken++;
        end
      end
      opcode_jal: begin
        value = pc + 32'd4;
        write = 1'b1;
        next_pc = pc + {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
        taken++;
      end
      // Only the exact ECALL word stops, other encodings are no-ops
      default: halted = insn == 32'h0000_0073;
    endcase
    write = write && insn[11:7] != 5'd0;
    if (write) regs[insn[11:7]] = value;
    r.pc = pc;
    r.insn = insn;
    r.we = write;
    r.rd = insn[11:7];
    r.data = value;
    trace.push_back(r);
    pc = next_pc;
    steps++;
  end
endfunction

`endif

// File: test/tb_rv_pipeline.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rv_pipeline import rv_pkg::*; ();

  // One retired instruction as the reference sees it
  typedef struct packed {
    word_t pc;
    word_t insn;
    logic we;
    reg_idx_t rd;
    word_t data;
  } retire_t;

  localparam word_t ecall_word = 32'h0000_0073;

  logic clk;
  logic rst;
  word_t pc_to_imem;
  word_t insn_from_imem;
  logic halt;
  word_t trace_writeback_pc;
  word_t trace_writeback_insn;
  cycle_status_e trace_writeback_cycle_status;
  logic trace_writeback_we;
  reg_idx_t trace_writeback_rd;
  word_t trace_writeback_data;

  // Program under construction, and the words fetch sees
  word_t prog[$];
  word_t imem[$];
  retire_t expected[$];
  int exp_taken;
  int ret_idx;
  int bubbles;
  logic checking;
  logic done;
  logic started;
  string test_name;

  rv_pipeline rv_pipeline_i (
    .clk(clk),
    .rst(rst),
    .pc_to_imem(pc_to_imem),
    .insn_from_imem(insn_from_imem),
    .halt(halt),
    .trace_writeback_pc(trace_writeback_pc),
    .trace_writeback_insn(trace_writeback_insn),
    .trace_writeback_cycle_status(trace_writeback_cycle_status),
    .trace_writeback_we(trace_writeback_we),
    .trace_writeback_rd(trace_writeback_rd),
    .trace_writeback_data(trace_writeback_data)
  );

  always #2 clk = ~clk;

  // Instruction memory, nop past the end of the program
  always @(negedge clk) begin : serve_imem
    int idx;
    idx = int'(pc_to_imem >> 2);
    if (idx < imem.size()) begin
      insn_from_imem <= imem[idx];
    end else begin
      insn_from_imem <= insn_nop;
    end
  end

  task automatic fail_stop(input string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string what, input word_t exp, input word_t act);
    if (exp !== act) begin
      fail_stop($sformatf("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act));
    end
  endtask

  task automatic check_index(input string what, input reg_idx_t exp, input reg_idx_t act);
    if (exp !== act) begin
      fail_stop($sformatf("[ERROR] %s %s: expected x%0d, actual x%0d", test_name, what,
                          exp, act));
    end
  endtask

  task automatic check_status(input string what, input cycle_status_e exp,
                              input cycle_status_e act);
    if (exp !== act) begin
      fail_stop($sformatf("[ERROR] %s %s: expected %s, actual %s", test_name, what,
                          exp.name(), act.name()));
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      fail_stop($sformatf("[ERROR] %s %s: expected %b, actual %b", test_name, what, exp, act));
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    if (exp != act) begin
      fail_stop($sformatf("[ERROR] %s %s: expected %0d, actual %0d", test_name, what, exp, act));
    end
  endtask

  // Writeback trace against the reference list, sampled mid-cycle
  always @(negedge clk) begin : compare_writeback
    retire_t e;
    if (checking && !done) begin
      if (trace_writeback_cycle_status == cycle_no_stall) begin
        started = 1'b1;
        if (ret_idx >= expected.size()) begin
          fail_stop($sformatf("%s: more instructions retired than the reference", test_name));
        end
        e = expected[ret_idx];
        check_word("pc", e.pc, trace_writeback_pc);
        check_word("insn", e.insn, trace_writeback_insn);
        check_flag("we", e.we, trace_writeback_we);
        if (e.we) begin
          check_index("rd", e.rd, trace_writeback_rd);
          check_word("rd data", e.data, trace_writeback_data);
        end
        check_flag("halt", e.insn == ecall_word, halt);
        ret_idx++;
      end else if (trace_writeback_cycle_status == cycle_taken_branch) begin
        started = 1'b1;
        bubbles++;
        check_flag("bubble we", 1'b0, trace_writeback_we);
        check_flag("bubble halt", 1'b0, halt);
      end else begin
        // Reset slots only until the first fetched slot arrives
        check_status("status", started ? cycle_no_stall : cycle_reset,
                     trace_writeback_cycle_status);
      end
      if (halt) begin
        check_count("retired count", expected.size(), ret_idx);
        check_count("bubble count", 2 * exp_taken, bubbles);
        done = 1'b1;
      end
    end
  end

  // Instruction encoders
  function automatic word_t i_type(input logic [2:0] f3, input reg_idx_t rd,
                                   input reg_idx_t rs1, input int imm);
    return {imm[11:0], rs1, f3, rd, opcode_reg_imm};
  endfunction

  function automatic word_t shift_word(input logic [2:0] f3, input logic [6:0] f7,
                                       input reg_idx_t rd, input reg_idx_t rs1, input int shamt);
    return {f7, shamt[4:0], rs1, f3, rd, opcode_reg_imm};
  endfunction

  function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                   input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, opcode_reg_reg};
  endfunction

  function automatic word_t lui_word(input reg_idx_t rd, input int upper);
    return {upper[19:0], rd, opcode_lui};
  endfunction

  function automatic word_t b_type(input logic [2:0] f3, input reg_idx_t rs1,
                                   input reg_idx_t rs2, input int off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opcode_branch};
  endfunction

  function automatic word_t j_type(input reg_idx_t rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd, opcode_jal};
  endfunction

  // Legal ALU op or LUI over x0..x7
  function automatic word_t random_alu_word();
    int kind;
    logic [2:0] f3;
    logic [6:0] f7;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    kind = $urandom_range(0, 9);
    f3 = 3'($urandom_range(0, 7));
    rd = reg_idx_t'($urandom_range(0, 7));
    rs1 = reg_idx_t'($urandom_range(0, 7));
    rs2 = reg_idx_t'($urandom_range(0, 7));
    f7 = '0;
    if ((f3 == funct3_add_sub || f3 == funct3_srl_sra) && $urandom_range(0, 1) == 1) begin
      f7 = funct7_alt;
    end
    if (kind == 0) begin
      return lui_word(rd, $urandom);
    end else if (kind < 5) begin
      return r_type(f7, f3, rd, rs1, rs2);
    end else if (f3 == funct3_sll || f3 == funct3_srl_sra) begin
      return shift_word(f3, f7, rd, rs1, $urandom_range(0, 31));
    end
    return i_type(f3, rd, rs1, $urandom_range(0, 4095));
  endfunction

  // Reset, load, then run until the ECALL retires
  task automatic run_program(input string name);
    int cycles;
    int limit;
    test_name = name;
    checking = 1'b0;
    done = 1'b0;
    rst = 1'b1;
    prog.push_back(ecall_word);
    imem = prog;
    run_reference(prog, expected, exp_taken);
    ret_idx = 0;
    bubbles = 0;
    started = 1'b0;
    repeat (16) @(negedge clk);
    // Outputs quiet while held in reset
    check_flag("halt in reset", 1'b0, halt);
    check_flag("we in reset", 1'b0, trace_writeback_we);
    check_word("pc in reset", '0, trace_writeback_pc);
    check_word("insn in reset", '0, trace_writeback_insn);
    check_status("status in reset", cycle_reset, trace_writeback_cycle_status);
    checking = 1'b1;
    rst = 1'b0;
    limit = 4 * expected.size() + 64;
    cycles = 0;
    while (!done) begin
      @(negedge clk);
      cycles++;
      if (!done && cycles > limit) begin
        fail_stop($sformatf("%s: timeout, halt not seen within %0d cycles", name, limit));
      end
    end
    checking = 1'b0;
    $display("%s: %0d retired, %0d bubbles", name, ret_idx, bubbles);
  endtask

  task automatic immediate_ops();
    prog = {};
    prog.push_back(i_type(funct3_add_sub, 1, 0, -5));
    prog.push_back(lui_word(2, 'h80000));
    prog.push_back(i_type(funct3_add_sub, 2, 2, 2047));
    prog.push_back(i_type(funct3_slt, 3, 1, -4));
    prog.push_back(i_type(funct3_sltu, 4, 1, -4));
    prog.push_back(i_type(funct3_slt, 13, 2, 1));
    prog.push_back(i_type(funct3_xor, 5, 1, -1));
    prog.push_back(i_type(funct3_or, 6, 1, 'h0f0));
    prog.push_back(i_type(funct3_and, 7, 1, -16));
    prog.push_back(shift_word(funct3_sll, 7'b0, 8, 1, 4));
    prog.push_back(shift_word(funct3_srl_sra, 7'b0, 9, 2, 8));
    // SRAI must fill with ones
    prog.push_back(shift_word(funct3_srl_sra, funct7_alt, 10, 2, 8));
    prog.push_back(shift_word(funct3_srl_sra, funct7_alt, 11, 1, 31));
    prog.push_back(lui_word(12, 'h12345));
    run_program("immediate_ops");
  endtask

  task automatic register_ops();
    prog = {};
    prog.push_back(i_type(funct3_add_sub, 1, 0, -7));
    prog.push_back(i_type(funct3_add_sub, 2, 0, 3));
    prog.push_back(lui_word(3, 'hf0f00));
    prog.push_back(r_type(7'b0, funct3_add_sub, 4, 1, 2));
    prog.push_back(r_type(funct7_alt, funct3_add_sub, 5, 1, 2));
    prog.push_back(r_type(7'b0, funct3_sll, 6, 1, 2));
    prog.push_back(r_type(7'b0, funct3_srl_sra, 7, 1, 2));
    prog.push_back(r_type(funct7_alt, funct3_srl_sra, 8, 1, 2));
    prog.push_back(r_type(7'b0, funct3_slt, 9, 1, 2));
    prog.push_back(r_type(7'b0, funct3_sltu, 10, 1, 2));
    prog.push_back(r_type(7'b0, funct3_xor, 11, 1, 3));
    prog.push_back(r_type(7'b0, funct3_or, 12, 1, 3));
    prog.push_back(r_type(7'b0, funct3_and, 13, 1, 3));
    // Write to x0 then read it back
    prog.push_back(r_type(7'b0, funct3_add_sub, 0, 1, 2));
    prog.push_back(r_type(7'b0, funct3_add_sub, 14, 0, 2));
    prog.push_back(r_type(funct7_alt, funct3_add_sub, 15, 2, 1));
    run_program("register_ops");
  endtask

  task automatic forwarding_chains();
    prog = {};
    prog.push_back(i_type(funct3_add_sub, 1, 0, 1));
    prog.push_back(i_type(funct3_add_sub, 1, 1, 2));
    prog.push_back(r_type(7'b0, funct3_add_sub, 2, 1, 1));
    prog.push_back(i_type(funct3_add_sub, 3, 0, 7));
    // x2 one apart, x3 back to back
    prog.push_back(r_type(funct7_alt, funct3_add_sub, 4, 2, 3));
    prog.push_back(i_type(funct3_add_sub, 5, 0, 100));
    prog.push_back(i_type(funct3_add_sub, 6, 0, 1));
    prog.push_back(i_type(funct3_add_sub, 7, 0, 2));
    // Three apart goes through the register file
    prog.push_back(r_type(7'b0, funct3_add_sub, 8, 5, 4));
    prog.push_back(shift_word(funct3_sll, 7'b0, 9, 8, 2));
    prog.push_back(r_type(7'b0, funct3_xor, 10, 9, 8));
    prog.push_back(r_type(7'b0, funct3_add_sub, 11, 10, 9));
    run_program("forwarding_chains");
  endtask

  // Branch over one marker write
  task automatic add_branch_case(input logic [2:0] f3, input reg_idx_t rs1,
                                 input reg_idx_t rs2, input reg_idx_t marker);
    prog.push_back(b_type(f3, rs1, rs2, 8));
    prog.push_back(i_type(funct3_add_sub, marker, marker, 1));
  endtask

  task automatic branch_kinds();
    prog = {};
    prog.push_back(i_type(funct3_add_sub, 1, 0, -1));
    prog.push_back(i_type(funct3_add_sub, 2, 0, 1));
    prog.push_back(i_type(funct3_add_sub, 3, 0, 1));
    add_branch_case(funct3_beq, 2, 3, 10);
    add_branch_case(funct3_beq, 1, 2, 11);
    add_branch_case(funct3_bne, 1, 2, 12);
    add_branch_case(funct3_bne, 2, 3, 13);
    add_branch_case(funct3_blt, 1, 2, 14);
    add_branch_case(funct3_blt, 2, 1, 15);
    add_branch_case(funct3_bge, 2, 1, 16);
    add_branch_case(funct3_bge, 1, 2, 17);
    add_branch_case(funct3_bltu, 2, 1, 18);
    add_branch_case(funct3_bltu, 1, 2, 19);
    add_branch_case(funct3_bgeu, 1, 2, 20);
    add_branch_case(funct3_bgeu, 2, 1, 21);
    // Backward loop, three passes
    prog.push_back(i_type(funct3_add_sub, 4, 0, 3));
    prog.push_back(i_type(funct3_add_sub, 4, 4, -1));
    prog.push_back(i_type(funct3_add_sub, 5, 5, 1));
    prog.push_back(b_type(funct3_bne, 4, 0, -8));
    run_program("branch_kinds");
  endtask

  task automatic jal_links();
    prog = {};
    prog.push_back(i_type(funct3_add_sub, 1, 0, 5));
    prog.push_back(j_type(2, 12));
    prog.push_back(i_type(funct3_add_sub, 3, 0, 1));
    prog.push_back(i_type(funct3_add_sub, 3, 0, 2));
    // Link value used right away
    prog.push_back(r_type(7'b0, funct3_add_sub, 4, 2, 1));
    prog.push_back(j_type(0, 8));
    prog.push_back(i_type(funct3_add_sub, 5, 0, 1));
    prog.push_back(j_type(6, 4));
    prog.push_back(i_type(funct3_add_sub, 7, 6, 0));
    run_program("jal_links");
  endtask

  task automatic random_alu();
    prog = {};
    for (int i = 0; i < 200; i++) begin
      prog.push_back(random_alu_word());
    end
    run_program("random_alu");
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    insn_from_imem = insn_nop;
    checking = 1'b0;
    done = 1'b0;
    started = 1'b0;
    ret_idx = 0;
    bubbles = 0;
    exp_taken = 0;
    test_name = "startup";
    void'($urandom(97133));
    @(negedge clk);
    immediate_ops();
    register_ops();
    forwarding_chains();
    branch_kinds();
    jal_links();
    random_alu();
    $display("all tests passed");
    $finish;
  end

  `include "rv_ref_model.svh"

endmodule

`default_nettype wire
